// ==== files.f ====
+incdir+test
logic/fpu_types_pkg.sv
logic/fp32_format_pkg.sv
logic/fpu_pipe_ctrl.sv
logic/fsqrt_lane.sv
logic/fclass_lane.sv
logic/fpu_sqrt_unit.sv
test/fpu_sqrt_tb.sv

// ==== test/fpu_sqrt_ref.svh ====
`ifndef FPU_SQRT_REF_SVH
`define FPU_SQRT_REF_SVH

// Largest r with r*r <= x, found one bit at a time.
function automatic logic [31:0] int_sqrt(input logic [63:0] x);
    logic [63:0] r;
    logic [63:0] c;
    r = '0;
    for (int b = 25; b >= 0; b--) begin
        c = r | (64'd1 << b);
        if (c * c <= x) begin
            r = c;
        end
    end
    return r[31:0];
endfunction

// Returns {flags, result} for a binary32 square root, nearest even.
function automatic logic [36:0] sqrt_ref(input logic [31:0] a);
    logic [FP32_EXP_BITS-1:0] e;
    logic [FP32_MAN_BITS-1:0] m;
    int                       unb;
    int                       half;
    logic [63:0]              x;
    logic [31:0]              root;
    logic [63:0]              rem;
    logic [31:0]              res;
    fflags_t                  fl;
    e  = a[30:23];
    m  = a[22:0];
    fl = '0;
    if (e == '1 && m != '0) begin
        res   = FP32_QNAN;
        fl.NV = ~m[FP32_MAN_BITS-1]; // Signaling NaN only.
    end else if (e == '0) begin
        res = {a[31], 31'b0}; // Zero, or a flushed subnormal.
    end else if (a[31]) begin
        res   = FP32_QNAN;
        fl.NV = 1'b1;
    end else if (e == '1) begin
        res = a;
    end else begin
        unb  = int'(e) - FP32_BIAS;
        // Odd exponent moves one factor of two into the significand.
        x    = {40'b0, 1'b1, m} << ((unb % 2 != 0) ? 24 : 23);
        half = (unb % 2 != 0) ? (unb - 1) / 2 : unb / 2;
        root = int_sqrt(x);
        rem  = x - root * root;
        fl.NX = (rem != 0);
        // Exact root lies above root + 0.5 exactly when rem > root.
        res  = {1'b0, 8'(half + FP32_BIAS), root[22:0]} + ((rem > root) ? 32'd1 : 32'd0);
    end
    return {fl, res};
endfunction

function automatic logic [9:0] class_ref(input logic [31:0] a);
    logic [9:0] mask;
    mask = '0;
    if (a[30:23] == 8'hFF && a[22:0] != 0) begin
        mask[a[22] ? CLASS_QNAN : CLASS_SNAN] = 1'b1;
    end else if (a[30:23] == 8'hFF) begin
        mask[a[31] ? CLASS_NEG_INF : CLASS_POS_INF] = 1'b1;
    end else if (a[30:0] == 0) begin
        mask[a[31] ? CLASS_NEG_ZERO : CLASS_POS_ZERO] = 1'b1;
    end else if (a[30:23] == 8'h00) begin
        mask[a[31] ? CLASS_NEG_SUB : CLASS_POS_SUB] = 1'b1;
    end else begin
        mask[a[31] ? CLASS_NEG_NORM : CLASS_POS_NORM] = 1'b1;
    end
    return mask;
endfunction

function automatic logic [36:0] expected_response(input fpu_op_t o, input logic [31:0] a);
    if (o == OP_CLASS) begin
        return {5'b0, 22'b0, class_ref(a)};
    end
    return sqrt_ref(a);
endfunction

`endif

// ==== test/fpu_sqrt_tb.sv ====
`timescale 1ns/1ps

module fpu_sqrt_tb
    import fpu_types_pkg::*;
    import fp32_format_pkg::*;
();

    localparam int NUM_LANES  = 4;
    localparam int TAGW       = 6;
    localparam int LATENCY    = 5;
    localparam int WAIT_LIMIT = 200;

    logic                       clk;
    logic                       rst;
    logic                       valid_in;
    logic                       ready_in;
    logic [TAGW-1:0]            tag_in;
    fpu_op_t                    op;
    logic [FRM_BITS-1:0]        frm;
    logic [NUM_LANES-1:0][31:0] dataa;
    logic [NUM_LANES-1:0][31:0] result;
    fflags_t [NUM_LANES-1:0]    fflags;
    logic [TAGW-1:0]            tag_out;
    logic                       valid_out;
    logic                       ready_out;

    logic [31:0]                rand_state;
    logic [31:0]                bp_state;
    logic                       bp_on;
    logic [TAGW-1:0]            next_tag;
    logic [NUM_LANES-1:0][31:0] req_data;
    logic [NUM_LANES-1:0][31:0] sent_data_q [$];
    fpu_op_t                    sent_op_q [$];
    logic [TAGW-1:0]            sent_tag_q [$];
    logic [31:0]                list_q [$];
    logic                       was_stalled;
    logic [NUM_LANES-1:0][31:0] held_result;
    fflags_t [NUM_LANES-1:0]    held_flags;
    logic [TAGW-1:0]            held_tag;
    int                         errors;
    int                         timeouts;
    int                         checked;
    int                         test_num;
    int                         tests_failed;
    int                         fail_before;

    `include "fpu_sqrt_ref.svh"

    fpu_sqrt_unit #(
        .NUM_LANES (NUM_LANES),
        .TAGW      (TAGW),
        .LATENCY   (LATENCY)
    ) fpu_sqrt_unit_inst (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (valid_in),
        .ready_in  (ready_in),
        .tag_in    (tag_in),
        .op        (op),
        .frm       (frm),
        .dataa     (dataa),
        .result    (result),
        .fflags    (fflags),
        .tag_out   (tag_out),
        .valid_out (valid_out),
        .ready_out (ready_out)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] rand_word();
        rand_state = lcg_step(rand_state);
        return rand_state;
    endfunction

    function automatic logic [31:0] rand_normal();
        logic [31:0] m;
        logic [31:0] e;
        m = rand_word();
        e = rand_word();
        return {1'b0, 8'(1 + e[31:24] % 254), m[31:9]}; // Exponent 1 to 254.
    endfunction

    function automatic logic [31:0] rand_operand();
        logic [31:0] r;
        r = rand_word();
        return (r[27:25] == 3'd0) ? rand_word() : rand_normal(); // Some of any class.
    endfunction

    // Random back-pressure on the output side.
    always @(posedge clk) begin
        bp_state  <= lcg_step(bp_state);
        ready_out <= bp_on ? bp_state[17] : 1'b1;
    end

    task automatic report_error(input string msg);
        errors++;
        $display("Error at %0d ns: %s", $time, msg);
    endtask

    task automatic compare_head();
        logic [36:0] exp_v;
        if (sent_tag_q.size() == 0) begin
            report_error($sformatf("result with tag %0d and nothing outstanding", tag_out));
        end else begin
            if (tag_out !== sent_tag_q[0]) begin
                report_error($sformatf("tag %0d, expected %0d", tag_out, sent_tag_q[0]));
            end
            for (int i = 0; i < NUM_LANES; i++) begin
                exp_v = expected_response(sent_op_q[0], sent_data_q[0][i]);
                if ({fflags[i], result[i]} !== exp_v) begin
                    report_error($sformatf("lane %0d op %0d a=%h got %h/%h expected %h/%h",
                        i, sent_op_q[0], sent_data_q[0][i], result[i], fflags[i],
                        exp_v[31:0], exp_v[36:32]));
                end
            end
            checked++;
            sent_tag_q.pop_front();
            sent_op_q.pop_front();
            sent_data_q.pop_front();
        end
    endtask

    // Sampled at the falling edge once every output has settled.
    always @(negedge clk) begin
        if (rst) begin
            was_stalled = 1'b0;
        end else begin
            if (ready_in !== ~(valid_out & ~ready_out)) begin
                report_error($sformatf("ready_in %b with valid_out %b ready_out %b",
                    ready_in, valid_out, ready_out));
            end
            if (was_stalled && (valid_out !== 1'b1 || result !== held_result ||
                    fflags !== held_flags || tag_out !== held_tag)) begin
                report_error("outputs changed while stalled");
            end
            if (valid_out === 1'b1 && ready_out === 1'b1) begin
                compare_head();
            end
            was_stalled = valid_out & ~ready_out;
            held_result = result;
            held_flags  = fflags;
            held_tag    = tag_out;
        end
    end

    task automatic send_request(input fpu_op_t o, input logic [NUM_LANES-1:0][31:0] d);
        int waited;
        if (timeouts != 0) begin
            return;
        end
        valid_in <= 1'b1;
        tag_in   <= next_tag;
        op       <= o;
        frm      <= rand_state[12:10]; // Ignored by the DUT.
        dataa    <= d;
        waited = 0;
        @(negedge clk);
        while (ready_in !== 1'b1 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (ready_in !== 1'b1) begin
            timeouts++;
            $display("Timeout: request with tag %0d was never accepted", next_tag);
        end else begin
            @(posedge clk);
            sent_data_q.push_back(d);
            sent_op_q.push_back(o);
            sent_tag_q.push_back(next_tag);
            next_tag = next_tag + 1'b1;
        end
    endtask

    task automatic idle_cycles(input int n);
        valid_in <= 1'b0;
        repeat (n) @(posedge clk);
    endtask

    task automatic wait_drain();
        int waited;
        valid_in <= 1'b0;
        waited = 0;
        while (sent_tag_q.size() != 0 && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (sent_tag_q.size() != 0) begin
            timeouts++;
            $display("Timeout: %0d results never came out", sent_tag_q.size());
        end
    endtask

    task automatic send_list(input fpu_op_t o);
        logic [NUM_LANES-1:0][31:0] d;
        for (int i = 0; i < list_q.size(); i += NUM_LANES) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                d[l] = list_q[(i + l) % list_q.size()]; // Short tail wraps around.
            end
            send_request(o, d);
        end
    endtask

    task automatic finish_test(input string name);
        int bad;
        bad = errors + timeouts - fail_before;
        test_num++;
        if (bad != 0) begin
            tests_failed++;
        end
        $display("Test %0d %s: %s, %0d problems", test_num, name, (bad == 0) ? "ok" : "bad", bad);
        fail_before = errors + timeouts;
    endtask

    initial begin
        rst        = 1'b1;
        valid_in   = 1'b1; // Offered during reset and never taken.
        tag_in     = '0;
        op         = OP_SQRT;
        frm        = '0;
        dataa      = '0;
        ready_out  = 1'b1;
        bp_on      = 1'b0;
        rand_state = 32'ha4de;
        bp_state   = ~32'ha4de;
        next_tag   = '0;
        errors     = 0;
        timeouts   = 0;
        checked    = 0;
        test_num   = 0;
        tests_failed = 0;
        fail_before  = 0;
        repeat (16) @(posedge clk);
        rst      <= 1'b0;
        valid_in <= 1'b0;
        @(posedge clk);

        @(negedge clk);
        if (ready_in !== 1'b1 || valid_out !== 1'b0) begin
            report_error("ready_in or valid_out wrong after reset");
        end
        @(posedge clk);
        list_q = '{32'h3F80_0000, 32'h4080_0000, 32'h4010_0000, 32'h3E80_0000,
                   32'h4974_2400, 32'h4110_0000, 32'h4180_0000, 32'h41C8_0000,
                   32'h3D80_0000, 32'h4280_0000, 32'h42C8_0000, 32'h4310_0000,
                   32'h40C8_0000, 32'h3F10_0000, 32'h3FC8_0000, 32'h4480_0000,
                   32'h4780_0000, 32'h4210_0000, 32'h4244_0000, 32'h3E10_0000};
        send_list(OP_SQRT);
        wait_drain();
        finish_test("perfect squares");

        list_q = '{32'hBF80_0000, 32'h7F80_0001, 32'h7FC0_0000, 32'hFFC1_2345,
                   32'h0000_0000, 32'h8000_0000, 32'h7F80_0000, 32'h0000_0001,
                   32'h807F_FFFF, 32'hFF80_0000, 32'h7FA0_0000, 32'h0040_0000};
        send_list(OP_SQRT);
        wait_drain();
        finish_test("special operands");

        repeat (200) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                req_data[l] = rand_normal();
            end
            send_request(OP_SQRT, req_data);
        end
        wait_drain();
        finish_test("random normals");

        list_q = '{32'hFF80_0000, 32'hBF80_0000, 32'h8000_0001, 32'h8000_0000,
                   32'h0000_0000, 32'h0000_0001, 32'h3F80_0000, 32'h7F80_0000,
                   32'h7F80_0001, 32'h7FC0_0000};
        send_list(OP_CLASS);
        repeat (40) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                req_data[l] = rand_operand();
            end
            send_request(rand_word() & 32'h0001_0000 ? OP_CLASS : OP_SQRT, req_data);
        end
        wait_drain();
        finish_test("classify and mixed ops");

        bp_on <= 1'b1;
        repeat (150) begin
            if (rand_word() & 32'h0010_0000) begin
                idle_cycles(1); // Bubble.
            end
            for (int l = 0; l < NUM_LANES; l++) begin
                req_data[l] = rand_operand();
            end
            send_request(rand_word() & 32'h0001_0000 ? OP_CLASS : OP_SQRT, req_data);
        end
        wait_drain();
        bp_on <= 1'b0;
        repeat (LATENCY + 2) @(posedge clk); // Catches any extra result.
        finish_test("back-pressure stream");

        $display("Tests: %0d run, %0d failed, %0d results checked, %0d errors, %0d timeouts",
            test_num, tests_failed, checked, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== logic/fpu_sqrt_unit.sv ====
`timescale 1ns/1ps

module fpu_sqrt_unit
    import fpu_types_pkg::*;
#(
    parameter int NUM_LANES = 4,
    parameter int TAGW      = 6,
    parameter int LATENCY   = 5
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       valid_in,
    output logic                       ready_in,
    input  logic [TAGW-1:0]            tag_in,
    input  fpu_op_t                    op,
    input  logic [FRM_BITS-1:0]        frm,       // Only nearest-even is built.
    input  logic [NUM_LANES-1:0][31:0] dataa,
    output logic [NUM_LANES-1:0][31:0] result,
    output fflags_t [NUM_LANES-1:0]    fflags,
    output logic [TAGW-1:0]            tag_out,
    output logic                       valid_out,
    input  logic                       ready_out
);

    logic    enable;
    fpu_op_t op_out;

    fpu_pipe_ctrl #(
        .LATENCY (LATENCY),
        .TAGW    (TAGW)
    ) pipe_ctrl_inst (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (valid_in),
        .ready_in  (ready_in),
        .tag_in    (tag_in),
        .op        (op),
        .ready_out (ready_out),
        .valid_out (valid_out),
        .tag_out   (tag_out),
        .op_out    (op_out),
        .enable    (enable)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        logic [31:0] sqrt_res;
        fflags_t     sqrt_flags;
        logic [9:0]  class_mask;

        fsqrt_lane #(
            .LATENCY (LATENCY)
        ) fsqrt_inst (
            .clk    (clk),
            .enable (enable),
            .a      (dataa[i]),
            .result (sqrt_res),
            .fflags (sqrt_flags)
        );

        fclass_lane #(
            .LATENCY (LATENCY)
        ) fclass_inst (
            .clk        (clk),
            .enable     (enable),
            .a          (dataa[i]),
            .class_mask (class_mask)
        );

        assign result[i] = (op_out == OP_CLASS) ? {22'b0, class_mask} : sqrt_res;
        assign fflags[i] = (op_out == OP_CLASS) ? fflags_t'('0) : sqrt_flags; // Class never flags.
    end

endmodule

// ==== logic/fclass_lane.sv ====
`timescale 1ns/1ps

module fclass_lane
    import fp32_format_pkg::*;
#(
    parameter int LATENCY = 5
) (
    input  logic        clk,
    input  logic        enable,
    input  logic [31:0] a,
    output logic [9:0]  class_mask
);

    logic                     sign;
    logic [FP32_EXP_BITS-1:0] exp_f;
    logic [FP32_MAN_BITS-1:0] man_f;
    logic                     exp_zero;
    logic                     exp_ones;
    logic                     man_zero;
    logic [9:0]               mask_nx;
    logic [9:0]               mask_q [LATENCY];

    assign sign     = a[31];
    assign exp_f    = a[FP32_EXP_BITS+FP32_MAN_BITS-1:FP32_MAN_BITS];
    assign man_f    = a[FP32_MAN_BITS-1:0];
    assign exp_zero = (exp_f == '0);
    assign exp_ones = (exp_f == '1);
    assign man_zero = (man_f == '0);

    always_comb begin
        mask_nx = '0;
        if (exp_ones && !man_zero) begin
            if (man_f[FP32_MAN_BITS-1]) begin
                mask_nx[CLASS_QNAN] = 1'b1;
            end else begin
                mask_nx[CLASS_SNAN] = 1'b1;
            end
        end else if (exp_ones) begin
            mask_nx[sign ? CLASS_NEG_INF : CLASS_POS_INF] = 1'b1;
        end else if (exp_zero && man_zero) begin
            mask_nx[sign ? CLASS_NEG_ZERO : CLASS_POS_ZERO] = 1'b1;
        end else if (exp_zero) begin
            mask_nx[sign ? CLASS_NEG_SUB : CLASS_POS_SUB] = 1'b1;
        end else begin
            mask_nx[sign ? CLASS_NEG_NORM : CLASS_POS_NORM] = 1'b1;
        end
    end

    // Delay line matched to the square-root depth.
    always_ff @(posedge clk) begin
        if (enable) begin
            mask_q[0] <= mask_nx;
            for (int i = 1; i < LATENCY; i++) begin
                mask_q[i] <= mask_q[i-1];
            end
        end
    end

    assign class_mask = mask_q[LATENCY-1];

endmodule

// ==== logic/fsqrt_lane.sv ====
`timescale 1ns/1ps

module fsqrt_lane
    import fpu_types_pkg::*;
    import fp32_format_pkg::*;
#(
    parameter int LATENCY = 5
) (
    input  logic        clk,
    input  logic        enable,
    input  logic [31:0] a,
    output logic [31:0] result,
    output fflags_t     fflags
);

    localparam int ROOT_BITS = 26;                               // 24 + guard + one sticky.
    localparam int BPS       = (ROOT_BITS + LATENCY - 1) / LATENCY; // Root bits per stage.
    localparam int REM_W     = ROOT_BITS + 3;
    localparam int SIG_W     = FP32_MAN_BITS + 1;

    logic                     in_sign;
    logic [FP32_EXP_BITS-1:0] in_exp;
    logic [FP32_MAN_BITS-1:0] in_man;
    logic                     in_zero;
    logic                     in_inf;
    logic                     in_nan;
    logic [SIG_W-1:0]         in_sig;
    logic [FP32_EXP_BITS:0]   exp_sum;
    logic                     dec_spec;
    logic                     dec_spec_nv;
    logic [31:0]              dec_spec_res;
    logic [ROOT_BITS-1:0]     dec_rad;

    assign in_sign = a[31];
    assign in_exp  = a[FP32_EXP_BITS+FP32_MAN_BITS-1:FP32_MAN_BITS];
    assign in_man  = a[FP32_MAN_BITS-1:0];
    assign in_zero = (in_exp == '0); // Subnormals flush to zero.
    assign in_inf  = (in_exp == '1) && (in_man == '0);
    assign in_nan  = (in_exp == '1) && (in_man != '0);
    assign in_sig  = {1'b1, in_man};

    // Halves the unbiased exponent, bit 0 tells an odd exponent.
    assign exp_sum = {1'b0, in_exp} + FP32_BIAS[FP32_EXP_BITS:0];
    assign dec_rad = exp_sum[0] ? {in_sig, 2'b00} : {1'b0, in_sig, 1'b0};

    always_comb begin
        dec_spec     = 1'b1;
        dec_spec_nv  = 1'b0;
        dec_spec_res = FP32_QNAN;
        if (in_nan) begin
            dec_spec_nv = ~in_man[FP32_MAN_BITS-1]; // Signaling NaN.
        end else if (in_zero) begin
            dec_spec_res = {in_sign, 31'b0};
        end else if (in_sign) begin
            dec_spec_nv = 1'b1;
        end else if (in_inf) begin
            dec_spec_res = a;
        end else begin
            dec_spec = 1'b0;
        end
    end

    for (genvar s = 0; s < LATENCY; s++) begin : g_stage
        logic [REM_W-1:0]         rem_in;
        logic [ROOT_BITS-1:0]     root_in;
        logic [ROOT_BITS-1:0]     rad_in;
        logic [FP32_EXP_BITS-1:0] exp_in;
        logic                     spec_in;
        logic                     spec_nv_in;
        logic [31:0]              spec_res_in;
        logic [REM_W-1:0]         rem_nx;
        logic [ROOT_BITS-1:0]     root_nx;
        logic [ROOT_BITS-1:0]     rad_nx;

        if (s == 0) begin : g_first
            assign rem_in      = '0;
            assign root_in     = '0;
            assign rad_in      = dec_rad;
            assign exp_in      = exp_sum[FP32_EXP_BITS:1];
            assign spec_in     = dec_spec;
            assign spec_nv_in  = dec_spec_nv;
            assign spec_res_in = dec_spec_res;
        end else begin : g_next
            assign rem_in      = g_stage[s-1].g_reg.rem_q;
            assign root_in     = g_stage[s-1].g_reg.root_q;
            assign rad_in      = g_stage[s-1].g_reg.rad_q;
            assign exp_in      = g_stage[s-1].g_reg.exp_q;
            assign spec_in     = g_stage[s-1].g_reg.spec_q;
            assign spec_nv_in  = g_stage[s-1].g_reg.spec_nv_q;
            assign spec_res_in = g_stage[s-1].g_reg.spec_res_q;
        end

        // Restoring recurrence, two radicand bits in per root bit out.
        always_comb begin
            automatic logic [REM_W-1:0] trial;
            rem_nx  = rem_in;
            root_nx = root_in;
            rad_nx  = rad_in;
            for (int j = 0; j < BPS; j++) begin
                if (s * BPS + j < ROOT_BITS) begin
                    rem_nx = {rem_nx[REM_W-3:0], rad_nx[ROOT_BITS-1 -: 2]};
                    rad_nx = {rad_nx[ROOT_BITS-3:0], 2'b00};
                    trial  = {1'b0, root_nx, 2'b01};
                    if (rem_nx >= trial) begin
                        rem_nx  = rem_nx - trial;
                        root_nx = {root_nx[ROOT_BITS-2:0], 1'b1};
                    end else begin
                        root_nx = {root_nx[ROOT_BITS-2:0], 1'b0};
                    end
                end
            end
        end

        if (s < LATENCY - 1) begin : g_reg
            logic [REM_W-1:0]         rem_q;
            logic [ROOT_BITS-1:0]     root_q;
            logic [ROOT_BITS-1:0]     rad_q;
            logic [FP32_EXP_BITS-1:0] exp_q;
            logic                     spec_q;
            logic                     spec_nv_q;
            logic [31:0]              spec_res_q;

            always_ff @(posedge clk) begin
                if (enable) begin
                    rem_q      <= rem_nx;
                    root_q     <= root_nx;
                    rad_q      <= rad_nx;
                    exp_q      <= exp_in;
                    spec_q     <= spec_in;
                    spec_nv_q  <= spec_nv_in;
                    spec_res_q <= spec_res_in;
                end
            end
        end else begin : g_last
            logic    guard;
            logic    sticky;
            logic    round_up;
            fflags_t flags_nx;

            assign guard    = root_nx[1];
            assign sticky   = root_nx[0] | (rem_nx != '0);
            assign round_up = guard & (sticky | root_nx[2]); // Nearest even.

            always_comb begin
                flags_nx    = '0;
                flags_nx.NV = spec_in & spec_nv_in;
                flags_nx.NX = ~spec_in & (guard | sticky);
            end

            always_ff @(posedge clk) begin
                if (enable) begin
                    fflags <= flags_nx;
                    if (spec_in) begin
                        result <= spec_res_in;
                    end else begin
                        // Carry out of the fraction bumps the exponent.
                        result <= {1'b0, exp_in, root_nx[ROOT_BITS-2:2]} + {31'b0, round_up};
                    end
                end
            end
        end
    end

endmodule

// ==== logic/fpu_pipe_ctrl.sv ====
`timescale 1ns/1ps

module fpu_pipe_ctrl
    import fpu_types_pkg::*;
#(
    parameter int LATENCY = 5,
    parameter int TAGW    = 6
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            valid_in,
    output logic            ready_in,
    input  logic [TAGW-1:0] tag_in,
    input  fpu_op_t         op,
    input  logic            ready_out,
    output logic            valid_out,
    output logic [TAGW-1:0] tag_out,
    output fpu_op_t         op_out,
    output logic            enable
);

    logic               stall;
    logic [LATENCY-1:0] valid_q;
    logic [TAGW-1:0]    tag_q [LATENCY];
    fpu_op_t            op_q  [LATENCY];

    assign stall    = valid_out & ~ready_out; // Result waiting at the output.
    assign enable   = ~stall;
    assign ready_in = enable;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (enable) begin
            valid_q <= {valid_q[LATENCY-2:0], valid_in}; // Low input makes a bubble.
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            tag_q[0] <= tag_in;
            op_q[0]  <= op;
            for (int i = 1; i < LATENCY; i++) begin
                tag_q[i] <= tag_q[i-1];
                op_q[i]  <= op_q[i-1];
            end
        end
    end

    assign valid_out = valid_q[LATENCY-1];
    assign tag_out   = tag_q[LATENCY-1];
    assign op_out    = op_q[LATENCY-1]; // Steers the lane result select.

endmodule

// ==== logic/fp32_format_pkg.sv ====
package fp32_format_pkg;

    localparam int FP32_EXP_BITS = 8;
    localparam int FP32_MAN_BITS = 23;
    localparam int FP32_BIAS     = 127;

    localparam logic [31:0] FP32_QNAN = 32'h7FC0_0000; // Canonical quiet NaN.

    // Bit positions in the fclass mask.
    localparam int CLASS_NEG_INF  = 0;
    localparam int CLASS_NEG_NORM = 1;
    localparam int CLASS_NEG_SUB  = 2;
    localparam int CLASS_NEG_ZERO = 3;
    localparam int CLASS_POS_ZERO = 4;
    localparam int CLASS_POS_SUB  = 5;
    localparam int CLASS_POS_NORM = 6;
    localparam int CLASS_POS_INF  = 7;
    localparam int CLASS_SNAN     = 8;
    localparam int CLASS_QNAN     = 9;

endpackage

// ==== logic/fpu_types_pkg.sv ====
package fpu_types_pkg;

    localparam int FRM_BITS = 3; // RISC-V rounding-mode field.

    typedef enum logic [0:0] {
        OP_SQRT  = 1'b0,
        OP_CLASS = 1'b1
    } fpu_op_t;

    // Exception flags in fflags CSR order, NV in the top bit.
    typedef struct packed {
        logic NV; // Invalid operation.
        logic DZ; // Divide by zero.
        logic OF; // Overflow.
        logic UF; // Underflow.
        logic NX; // Inexact.
    } fflags_t;

endpackage
